/* verilog/tetris_pkg.sv */
// Shared types and helpers for the piece logic of the puzzle game.
// Playfield is 20 rows by 10 columns, row 0 at the top.
// Only the T, O and I shapes are defined; BLANK marks an empty cell.
`default_nettype none

package tetris_pkg;

    localparam int PLAYFIELD_ROWS = 20;
    localparam int PLAYFIELD_COLS = 10;
    localparam logic [4:0] SPAWN_ROW = 5'd1;
    localparam logic [3:0] SPAWN_COL = 4'd4;

    typedef enum logic [2:0] {BLANK, T, O, I} tile_type_t;

    // ordered clockwise.
    typedef enum logic [1:0] {
        ORIENTATION_0,
        ORIENTATION_R,
        ORIENTATION_2,
        ORIENTATION_L
    } orientation_t;

    typedef enum logic [2:0] {
        CMD_NONE,
        CMD_LEFT,
        CMD_RIGHT,
        CMD_DOWN,
        CMD_ROT_R,
        CMD_ROT_L,
        CMD_SPAWN
    } cmd_t;

    typedef struct packed {
        tile_type_t   tile_type;
        orientation_t orientation;
        logic [4:0]   row;
        logic [3:0]   col;
    } piece_t;

    typedef tile_type_t [PLAYFIELD_ROWS-1:0][PLAYFIELD_COLS-1:0] board_t;

    typedef struct packed {
        logic left_ok;
        logic right_ok;
        logic down_ok;
        logic rot_r_ok;
        logic rot_l_ok;
    } fit_t;

    typedef struct packed {
        logic signed [2:0] dr;
        logic signed [2:0] dc;
    } cell_offset_t;

    typedef cell_offset_t [3:0] cell_offsets_t;

    // offsets of the four cells from the piece origin.
    function automatic cell_offsets_t piece_cells(tile_type_t t, orientation_t o);
        cell_offsets_t     cells;
        logic signed [2:0] tmp;
        cells = '0;
        case (t)
            T: begin
                cells[0] = '{3'sd0, 3'sd0};
                cells[1] = '{3'sd0, -3'sd1};
                cells[2] = '{3'sd0, 3'sd1};
                cells[3] = '{-3'sd1, 3'sd0};
                // quarter turn clockwise per orientation step.
                for (int k = 0; k < 3; k++) begin
                    if (k < int'(o)) begin
                        for (int i = 0; i < 4; i++) begin
                            tmp = cells[i].dr;
                            cells[i].dr = cells[i].dc;
                            cells[i].dc = -tmp;
                        end
                    end
                end
            end
            O: begin
                cells[0] = '{3'sd0, 3'sd0};
                cells[1] = '{3'sd0, 3'sd1};
                cells[2] = '{3'sd1, 3'sd0};
                cells[3] = '{3'sd1, 3'sd1};
            end
            I: begin
                for (int i = 0; i < 4; i++) begin
                    if (o == ORIENTATION_R || o == ORIENTATION_L) begin
                        cells[i] = '{3'(i - 1), 3'sd0};
                    end else begin
                        cells[i] = '{3'sd0, 3'(i - 1)};
                    end
                end
            end
            default: cells = '0;
        endcase
        return cells;
    endfunction

    // absolute coordinate, signed so that off-field cells stay visible.
    function automatic logic signed [6:0] offset_pos(logic [4:0] base,
                                                     logic signed [2:0] delta);
        return $signed({2'b00, base}) + 7'($signed(delta));
    endfunction

    function automatic logic cell_free(board_t b, logic signed [6:0] r,
                                       logic signed [6:0] c);
        return r >= 0 && r < PLAYFIELD_ROWS && c >= 0 && c < PLAYFIELD_COLS &&
               b[r[4:0]][c[3:0]] == BLANK;
    endfunction

    function automatic piece_t spawn_piece(tile_type_t t);
        piece_t p;
        p.tile_type   = t;
        p.orientation = ORIENTATION_0;
        p.row         = SPAWN_ROW;
        p.col         = SPAWN_COL;
        return p;
    endfunction

endpackage

`default_nettype wire

/* verilog/piece_control.sv */
// Owns the falling piece and applies one command per cycle.
// Commands are plain strobes; a rejected command changes nothing.
// game_over holds until reset, and all commands are ignored then.
`timescale 1ns/1ps
`default_nettype none

module piece_control
    import tetris_pkg::*;
(
    input  logic       clk,
    input  logic       rst_l,
    input  cmd_t       cmd,
    input  tile_type_t spawn_type,
    input  fit_t       fit,
    input  logic       spawn_blocked,
    output piece_t     piece,
    output logic       piece_active,
    output logic       lock,
    output logic       rotated,
    output logic       shifted,
    output logic       game_over
);

    typedef enum logic [1:0] {
        EMPTY,
        FALLING,
        LOCKING,
        OVER
    } state_t;

    state_t state;

    always_ff @(posedge clk, negedge rst_l) begin
        if (!rst_l) begin
            state   <= EMPTY;
            piece   <= '0;
            rotated <= 1'b0;
            shifted <= 1'b0;
        end else begin
            rotated <= 1'b0;
            shifted <= 1'b0;
            case (state)
                EMPTY: begin
                    // a blank spawn type carries no piece.
                    if (cmd == CMD_SPAWN && spawn_type != BLANK) begin
                        if (spawn_blocked) begin
                            state <= OVER;
                        end else begin
                            piece <= spawn_piece(spawn_type);
                            state <= FALLING;
                        end
                    end
                end
                FALLING: begin
                    case (cmd)
                        CMD_LEFT: begin
                            if (fit.left_ok) begin
                                piece.col <= piece.col - 4'd1;
                                shifted   <= 1'b1;
                            end
                        end
                        CMD_RIGHT: begin
                            if (fit.right_ok) begin
                                piece.col <= piece.col + 4'd1;
                                shifted   <= 1'b1;
                            end
                        end
                        CMD_DOWN: begin
                            if (fit.down_ok) begin
                                piece.row <= piece.row + 5'd1;
                            end else begin
                                state <= LOCKING;
                            end
                        end
                        CMD_ROT_R: begin
                            if (fit.rot_r_ok) begin
                                piece.orientation <= orientation_t'(piece.orientation + 2'd1);
                                rotated           <= 1'b1;
                            end
                        end
                        CMD_ROT_L: begin
                            if (fit.rot_l_ok) begin
                                piece.orientation <= orientation_t'(piece.orientation - 2'd1);
                                rotated           <= 1'b1;
                            end
                        end
                        default: begin
                        end
                    endcase
                end
                // one cycle for the board and T-spin result to take the piece.
                LOCKING: state <= EMPTY;
                default: state <= OVER;
            endcase
        end
    end

    assign piece_active = (state == FALLING) || (state == LOCKING);
    assign lock         = (state == LOCKING);
    assign game_over    = (state == OVER);

endmodule

`default_nettype wire

/* verilog/move_checker.sv */
// Combinational fit tests for every candidate placement of the piece.
// A placement fits when all four cells are on the field and BLANK.
// Results are only meaningful while a piece is active.
`timescale 1ns/1ps
`default_nettype none

module move_checker
    import tetris_pkg::*;
(
    input  piece_t     piece,
    input  board_t     board,
    input  tile_type_t spawn_type,
    output fit_t       fit,
    output logic       spawn_blocked
);

    piece_t cand_left;
    piece_t cand_right;
    piece_t cand_down;
    piece_t cand_rot_r;
    piece_t cand_rot_l;

    function automatic logic piece_fits(piece_t p, board_t b);
        cell_offsets_t offs;
        logic          ok;
        offs = piece_cells(p.tile_type, p.orientation);
        ok   = 1'b1;
        for (int i = 0; i < 4; i++) begin
            if (!cell_free(b, offset_pos(p.row, offs[i].dr),
                           offset_pos({1'b0, p.col}, offs[i].dc))) begin
                ok = 1'b0;
            end
        end
        return ok;
    endfunction

    // column and row wrap past the field edge, so the range test catches it.
    always_comb begin
        cand_left              = piece;
        cand_left.col          = piece.col - 4'd1;
        cand_right             = piece;
        cand_right.col         = piece.col + 4'd1;
        cand_down              = piece;
        cand_down.row          = piece.row + 5'd1;
        cand_rot_r             = piece;
        cand_rot_r.orientation = orientation_t'(piece.orientation + 2'd1);
        cand_rot_l             = piece;
        cand_rot_l.orientation = orientation_t'(piece.orientation - 2'd1);
    end

    always_comb begin
        fit.left_ok   = piece_fits(cand_left, board);
        fit.right_ok  = piece_fits(cand_right, board);
        fit.down_ok   = piece_fits(cand_down, board);
        fit.rot_r_ok  = piece_fits(cand_rot_r, board);
        fit.rot_l_ok  = piece_fits(cand_rot_l, board);
        spawn_blocked = !piece_fits(spawn_piece(spawn_type), board);
    end

endmodule

`default_nettype wire

/* verilog/playfield_store.sv */
// Register array of locked tiles, all BLANK after reset.
// The piece is written on lock and is assumed to lie inside the field.
// Reads outside the field return BLANK.
`timescale 1ns/1ps
`default_nettype none

module playfield_store
    import tetris_pkg::*;
(
    input  logic       clk,
    input  logic       rst_l,
    input  piece_t     piece,
    input  logic       lock,
    output board_t     board,
    input  logic [4:0] rd_row,
    input  logic [3:0] rd_col,
    output tile_type_t rd_tile
);

    cell_offsets_t offs;
    logic [4:0]    wr_row [4];
    logic [3:0]    wr_col [4];

    // cell addresses of the piece being locked.
    always_comb begin
        offs = piece_cells(piece.tile_type, piece.orientation);
        for (int i = 0; i < 4; i++) begin
            wr_row[i] = piece.row + 5'($signed(offs[i].dr));
            wr_col[i] = piece.col + 4'($signed(offs[i].dc));
        end
    end

    always_ff @(posedge clk, negedge rst_l) begin
        if (!rst_l) begin
            for (int r = 0; r < PLAYFIELD_ROWS; r++) begin
                for (int c = 0; c < PLAYFIELD_COLS; c++) begin
                    board[r][c] <= BLANK;
                end
            end
        end else if (lock) begin
            for (int i = 0; i < 4; i++) begin
                board[wr_row[i]][wr_col[i]] <= piece.tile_type;
            end
        end
    end

    assign rd_tile = (rd_row < 5'(PLAYFIELD_ROWS) && rd_col < 4'(PLAYFIELD_COLS)) ?
                     board[rd_row][rd_col] : BLANK;

endmodule

`default_nettype wire

/* verilog/tspin_detector.sv */
// T-spin decision by the three-corner rule plus an immobility check.
// Off-field cells count as filled. The result is latched on lock and
// held until the next lock. The last-input memory restarts with each piece.
`timescale 1ns/1ps
`default_nettype none

module tspin_detector
    import tetris_pkg::*;
(
    input  logic   clk,
    input  logic   rst_l,
    input  piece_t piece,
    input  board_t board,
    input  fit_t   fit,
    input  logic   rotated,
    input  logic   shifted,
    input  logic   lock,
    output logic   tspin_detected
);

    typedef enum logic {
        MOVE,
        ROTATE
    } last_input_t;

    last_input_t       last_input;
    logic signed [6:0] row_up2;
    logic signed [6:0] row_up1;
    logic signed [6:0] row_dn1;
    logic signed [6:0] col_lt;
    logic signed [6:0] col_ctr;
    logic signed [6:0] col_rt;
    logic [3:0]        corners;
    logic              three_corners;
    logic              immobile;

    always_ff @(posedge clk, negedge rst_l) begin
        if (!rst_l) begin
            last_input     <= MOVE;
            tspin_detected <= 1'b0;
        end else if (lock) begin
            last_input     <= MOVE;
            tspin_detected <= piece.tile_type == T && last_input == ROTATE &&
                              three_corners && immobile;
        end else if (rotated) begin
            last_input <= ROTATE;
        end else if (shifted) begin
            last_input <= MOVE;
        end
    end

    assign row_up2 = offset_pos(piece.row, -3'sd2);
    assign row_up1 = offset_pos(piece.row, -3'sd1);
    assign row_dn1 = offset_pos(piece.row, 3'sd1);
    assign col_lt  = offset_pos({1'b0, piece.col}, -3'sd1);
    assign col_ctr = offset_pos({1'b0, piece.col}, 3'sd0);
    assign col_rt  = offset_pos({1'b0, piece.col}, 3'sd1);

    // diagonal corners around the origin.
    always_comb begin
        corners[0]    = !cell_free(board, row_up1, col_lt);
        corners[1]    = !cell_free(board, row_up1, col_rt);
        corners[2]    = !cell_free(board, row_dn1, col_lt);
        corners[3]    = !cell_free(board, row_dn1, col_rt);
        three_corners = $countones(corners) >= 3;
    end

    // no sideways move, and for R and L no room to be lifted one row.
    always_comb begin
        immobile = 1'b0;
        if (!fit.left_ok && !fit.right_ok) begin
            case (piece.orientation)
                ORIENTATION_R: immobile = !cell_free(board, row_up2, col_ctr) &&
                                          !cell_free(board, row_up1, col_rt);
                ORIENTATION_L: immobile = !cell_free(board, row_up2, col_ctr) &&
                                          !cell_free(board, row_up1, col_lt);
                // flat orientations are pinned from above by the corners.
                default:       immobile = 1'b1;
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/tetris_core.sv */
// Top level of the piece logic: control FSM, fit tests, locked
// playfield and T-spin detection. No line clearing or scoring.
`timescale 1ns/1ps
`default_nettype none

module tetris_core
    import tetris_pkg::*;
(
    input  logic       clk,
    input  logic       rst_l,
    input  cmd_t       cmd,
    input  tile_type_t spawn_type,
    input  logic [4:0] rd_row,
    input  logic [3:0] rd_col,
    output piece_t     piece,
    output logic       piece_active,
    output logic       lock,
    output logic       tspin_detected,
    output logic       game_over,
    output tile_type_t rd_tile
);

    board_t board;
    fit_t   fit;
    logic   spawn_blocked;
    logic   rotated;
    logic   shifted;

    piece_control u_piece_control (
        .clk           (clk),
        .rst_l         (rst_l),
        .cmd           (cmd),
        .spawn_type    (spawn_type),
        .fit           (fit),
        .spawn_blocked (spawn_blocked),
        .piece         (piece),
        .piece_active  (piece_active),
        .lock          (lock),
        .rotated       (rotated),
        .shifted       (shifted),
        .game_over     (game_over)
    );

    move_checker u_move_checker (
        .piece         (piece),
        .board         (board),
        .spawn_type    (spawn_type),
        .fit           (fit),
        .spawn_blocked (spawn_blocked)
    );

    playfield_store u_playfield_store (
        .clk     (clk),
        .rst_l   (rst_l),
        .piece   (piece),
        .lock    (lock),
        .board   (board),
        .rd_row  (rd_row),
        .rd_col  (rd_col),
        .rd_tile (rd_tile)
    );

    tspin_detector u_tspin_detector (
        .clk            (clk),
        .rst_l          (rst_l),
        .piece          (piece),
        .board          (board),
        .fit            (fit),
        .rotated        (rotated),
        .shifted        (shifted),
        .lock           (lock),
        .tspin_detected (tspin_detected)
    );

endmodule

`default_nettype wire

/* tests/tetris_core_assertions.sv */
// Concurrent checks on the control FSM, bound into piece_control.
// All properties are disabled while rst_l is low.
`timescale 1ns/1ps
`default_nettype none

module tetris_core_assertions
    import tetris_pkg::*;
(
    input logic clk,
    input logic rst_l,
    input cmd_t cmd,
    input logic down_ok,
    input logic lock,
    input logic piece_active,
    input logic falling,
    input logic rotated,
    input logic shifted,
    input logic game_over
);

    a_lock_one_cycle: assert property (@(posedge clk) disable iff (!rst_l)
        lock |=> !lock)
        else $error("lock held for more than one cycle");

    // lock only follows a blocked down while falling, and the piece is still active.
    a_lock_after_blocked_down: assert property (@(posedge clk) disable iff (!rst_l)
        lock |-> piece_active && $past(falling && cmd == CMD_DOWN && !down_ok))
        else $error("lock without a blocked down command while falling");

    a_rot_shift_exclusive: assert property (@(posedge clk) disable iff (!rst_l)
        !(rotated && shifted))
        else $error("rotated and shifted high together");

    a_game_over_holds: assert property (@(posedge clk) disable iff (!rst_l)
        game_over |=> game_over)
        else $error("game_over fell outside reset");

endmodule

bind piece_control tetris_core_assertions u_assert (
    .clk          (clk),
    .rst_l        (rst_l),
    .cmd          (cmd),
    .down_ok      (fit.down_ok),
    .lock         (lock),
    .piece_active (piece_active),
    .falling      (state == FALLING),
    .rotated      (rotated),
    .shifted      (shifted),
    .game_over    (game_over)
);

`default_nettype wire

/* tests/tetris_core_tb.sv */
// Table-driven testbench for tetris_core.
// Each step repeats its command a fixed number of times, or with reps 0
// keeps sending it until lock and then idles one cycle before checking.
`timescale 1ns/1ps
`default_nettype none

module tetris_core_tb
    import tetris_pkg::*;
;

    localparam int LOCK_TIMEOUT = 40;
    localparam orientation_t OR0 = ORIENTATION_0;
    localparam orientation_t ORR = ORIENTATION_R;
    localparam orientation_t OR2 = ORIENTATION_2;
    localparam orientation_t ORL = ORIENTATION_L;

    typedef struct packed {
        logic [2:0] test;
        cmd_t       cmd;
        tile_type_t spawn;
        logic [4:0] reps;
        piece_t     exp_piece;
        logic       exp_active;
        logic       exp_lock;
        logic       exp_tspin;
        logic       exp_over;
        logic       probe;
        logic [4:0] prow;
        logic [3:0] pcol;
        tile_type_t ptile;
    } step_t;

    logic       clk;
    logic       rst_l;
    cmd_t       cmd;
    tile_type_t spawn_type;
    logic [4:0] rd_row;
    logic [3:0] rd_col;
    piece_t     piece;
    logic       piece_active;
    logic       lock;
    logic       tspin_detected;
    logic       game_over;
    tile_type_t rd_tile;

    step_t steps[$];
    int    errors;
    string test_name [1:6] = '{"spawn and move", "rotation", "drop and lock",
                               "t-spin detected", "not a t-spin", "game over"};

    tetris_core uut (
        .clk            (clk),
        .rst_l          (rst_l),
        .cmd            (cmd),
        .spawn_type     (spawn_type),
        .rd_row         (rd_row),
        .rd_col         (rd_col),
        .piece          (piece),
        .piece_active   (piece_active),
        .lock           (lock),
        .tspin_detected (tspin_detected),
        .game_over      (game_over),
        .rd_tile        (rd_tile)
    );

    always #2 clk = ~clk;

    function automatic piece_t make_piece(tile_type_t t, orientation_t o, int r, int c);
        piece_t p;
        p.tile_type   = t;
        p.orientation = o;
        p.row         = 5'(r);
        p.col         = 4'(c);
        return p;
    endfunction

    function automatic string piece_str(piece_t p);
        return $sformatf("%s/%s/r%0d/c%0d", p.tile_type.name(), p.orientation.name(),
                         p.row, p.col);
    endfunction

    task automatic add_step(input int test, input cmd_t c, input tile_type_t st,
                            input int reps, input piece_t p, input logic act,
                            input logic lk, input logic ts, input logic ov,
                            input int prow = -1, input int pcol = 0,
                            input tile_type_t pt = BLANK);
        step_t s;
        s.test       = 3'(test);
        s.cmd        = c;
        s.spawn      = st;
        s.reps       = 5'(reps);
        s.exp_piece  = p;
        s.exp_active = act;
        s.exp_lock   = lk;
        s.exp_tspin  = ts;
        s.exp_over   = ov;
        s.probe      = prow >= 0;
        s.prow       = (prow >= 0) ? 5'(prow) : 5'd0;
        s.pcol       = 4'(pcol);
        s.ptile      = pt;
        steps.push_back(s);
    endtask

    task automatic check_piece(input string name, input piece_t exp, input piece_t act);
        if (act !== exp) begin
            $display("** Error at %0t: %s expected %s got %s", $time, name,
                     piece_str(exp), piece_str(act));
            errors++;
        end
    endtask

    task automatic check_tile(input string name, input tile_type_t exp,
                              input tile_type_t act);
        if (act !== exp) begin
            $display("** Error at %0t: %s expected %s got %s", $time, name,
                     exp.name(), act.name());
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("** Error at %0t: %s expected %b got %b", $time, name, exp, act);
            errors++;
        end
    endtask

    // board built up here: O at rows 18-19 cols 0-1, I pieces at rows 19, 18
    // and 17, an O overhang at rows 15-16, which leaves a T slot at (17,2).
    task automatic build_table();
        add_step(1, CMD_NONE,  BLANK, 1, '0, 0, 0, 0, 0);
        add_step(1, CMD_SPAWN, O,     1, make_piece(O, OR0, 1, 4), 1, 0, 0, 0);
        add_step(1, CMD_LEFT,  BLANK, 4, make_piece(O, OR0, 1, 0), 1, 0, 0, 0);
        add_step(1, CMD_LEFT,  BLANK, 1, make_piece(O, OR0, 1, 0), 1, 0, 0, 0);
        add_step(3, CMD_DOWN,  BLANK, 0, make_piece(O, OR0, 18, 0), 0, 0, 0, 0, 18, 0, O);
        add_step(3, CMD_NONE,  BLANK, 1, make_piece(O, OR0, 18, 0), 0, 0, 0, 0, 18, 1, O);
        add_step(3, CMD_NONE,  BLANK, 1, make_piece(O, OR0, 18, 0), 0, 0, 0, 0, 19, 0, O);
        add_step(3, CMD_NONE,  BLANK, 1, make_piece(O, OR0, 18, 0), 0, 0, 0, 0, 19, 1, O);
        add_step(3, CMD_LEFT,  BLANK, 1, make_piece(O, OR0, 18, 0), 0, 0, 0, 0, 19, 2, BLANK);
        add_step(3, CMD_NONE,  BLANK, 1, make_piece(O, OR0, 18, 0), 0, 0, 0, 0, 17, 0, BLANK);
        add_step(2, CMD_SPAWN, I,     1, make_piece(I, OR0, 1, 4), 1, 0, 0, 0);
        add_step(2, CMD_ROT_R, BLANK, 1, make_piece(I, ORR, 1, 4), 1, 0, 0, 0);
        add_step(2, CMD_LEFT,  BLANK, 4, make_piece(I, ORR, 1, 0), 1, 0, 0, 0);
        // horizontal at col 0 would reach col -1.
        add_step(2, CMD_ROT_L, BLANK, 1, make_piece(I, ORR, 1, 0), 1, 0, 0, 0);
        add_step(2, CMD_RIGHT, BLANK, 3, make_piece(I, ORR, 1, 3), 1, 0, 0, 0);
        add_step(2, CMD_ROT_L, BLANK, 1, make_piece(I, OR0, 1, 3), 1, 0, 0, 0);
        add_step(2, CMD_DOWN,  BLANK, 0, make_piece(I, OR0, 19, 3), 0, 0, 0, 0, 19, 5, I);
        add_step(2, CMD_SPAWN, I,     1, make_piece(I, OR0, 1, 4), 1, 0, 0, 0);
        add_step(2, CMD_DOWN,  BLANK, 16, make_piece(I, OR0, 17, 4), 1, 0, 0, 0);
        // vertical would overlap the I locked on row 19.
        add_step(2, CMD_ROT_R, BLANK, 1, make_piece(I, OR0, 17, 4), 1, 0, 0, 0);
        add_step(2, CMD_DOWN,  BLANK, 0, make_piece(I, OR0, 18, 4), 0, 0, 0, 0, 18, 6, I);
        add_step(4, CMD_SPAWN, I,     1, make_piece(I, OR0, 1, 4), 1, 0, 0, 0);
        add_step(4, CMD_RIGHT, BLANK, 1, make_piece(I, OR0, 1, 5), 1, 0, 0, 0);
        add_step(4, CMD_DOWN,  BLANK, 0, make_piece(I, OR0, 17, 5), 0, 0, 0, 0, 17, 7, I);
        add_step(4, CMD_SPAWN, O,     1, make_piece(O, OR0, 1, 4), 1, 0, 0, 0);
        add_step(4, CMD_LEFT,  BLANK, 1, make_piece(O, OR0, 1, 3), 1, 0, 0, 0);
        add_step(4, CMD_DOWN,  BLANK, 0, make_piece(O, OR0, 15, 3), 0, 0, 0, 0, 16, 3, O);
        add_step(1, CMD_SPAWN, T,     1, make_piece(T, OR0, 1, 4), 1, 0, 0, 0);
        add_step(1, CMD_LEFT,  BLANK, 1, make_piece(T, OR0, 1, 3), 1, 0, 0, 0);
        add_step(1, CMD_RIGHT, BLANK, 1, make_piece(T, OR0, 1, 4), 1, 0, 0, 0);
        add_step(1, CMD_LEFT,  BLANK, 3, make_piece(T, OR0, 1, 1), 1, 0, 0, 0);
        add_step(1, CMD_LEFT,  BLANK, 1, make_piece(T, OR0, 1, 1), 1, 0, 0, 0);
        add_step(2, CMD_ROT_R, BLANK, 4, make_piece(T, OR0, 1, 1), 1, 0, 0, 0);
        add_step(2, CMD_ROT_L, BLANK, 1, make_piece(T, ORL, 1, 1), 1, 0, 0, 0);
        add_step(2, CMD_ROT_R, BLANK, 1, make_piece(T, OR0, 1, 1), 1, 0, 0, 0);
        add_step(4, CMD_RIGHT, BLANK, 1, make_piece(T, OR0, 1, 2), 1, 0, 0, 0);
        add_step(4, CMD_ROT_L, BLANK, 1, make_piece(T, ORL, 1, 2), 1, 0, 0, 0);
        add_step(4, CMD_DOWN,  BLANK, 16, make_piece(T, ORL, 17, 2), 1, 0, 0, 0);
        add_step(4, CMD_ROT_L, BLANK, 1, make_piece(T, OR2, 17, 2), 1, 0, 0, 0);
        add_step(4, CMD_DOWN,  BLANK, 0, make_piece(T, OR2, 17, 2), 0, 0, 1, 0, 18, 2, T);
        // result holds across the next piece, and an O lock clears it.
        add_step(5, CMD_SPAWN, O,     1, make_piece(O, OR0, 1, 4), 1, 0, 1, 0);
        add_step(5, CMD_LEFT,  BLANK, 4, make_piece(O, OR0, 1, 0), 1, 0, 1, 0);
        add_step(5, CMD_DOWN,  BLANK, 0, make_piece(O, OR0, 15, 0), 0, 0, 0, 0, 16, 1, O);
        add_step(5, CMD_SPAWN, T,     1, make_piece(T, OR0, 1, 4), 1, 0, 0, 0);
        add_step(5, CMD_ROT_R, BLANK, 1, make_piece(T, ORR, 1, 4), 1, 0, 0, 0);
        add_step(5, CMD_RIGHT, BLANK, 4, make_piece(T, ORR, 1, 8), 1, 0, 0, 0);
        add_step(5, CMD_DOWN,  BLANK, 0, make_piece(T, ORR, 18, 8), 0, 0, 0, 0, 19, 8, T);
        // O stack at the spawn column, tops at rows 13 down to 1.
        for (int r = 13; r >= 1; r -= 2) begin
            add_step(6, CMD_SPAWN, O, 1, make_piece(O, OR0, 1, 4), 1, 0, 0, 0);
            add_step(6, CMD_DOWN, BLANK, 0, make_piece(O, OR0, r, 4), 0, 0, 0, 0, r, 5, O);
        end
        add_step(6, CMD_SPAWN, T,     1, make_piece(O, OR0, 1, 4), 0, 0, 0, 1);
        add_step(6, CMD_LEFT,  BLANK, 1, make_piece(O, OR0, 1, 4), 0, 0, 0, 1);
        add_step(6, CMD_SPAWN, I,     1, make_piece(O, OR0, 1, 4), 0, 0, 0, 1);
    endtask

    task automatic run_step(input step_t s);
        int n;
        cmd        = s.cmd;
        spawn_type = s.spawn;
        rd_row     = s.prow;
        rd_col     = s.pcol;
        if (s.reps == 0) begin
            n = 0;
            while (!lock && n < LOCK_TIMEOUT) begin
                @(posedge clk);
                #1;
                n++;
            end
            if (!lock) begin
                $display("timeout: no lock pulse after %0d cycles of %s", n, s.cmd.name());
                errors++;
            end
            cmd = CMD_NONE;
            @(posedge clk);
            #1;
        end else begin
            repeat (s.reps) begin
                @(posedge clk);
                #1;
            end
        end
        check_piece("piece", s.exp_piece, piece);
        check_bit("piece_active", s.exp_active, piece_active);
        check_bit("lock", s.exp_lock, lock);
        check_bit("tspin_detected", s.exp_tspin, tspin_detected);
        check_bit("game_over", s.exp_over, game_over);
        if (s.probe) begin
            check_tile("rd_tile", s.ptile, rd_tile);
        end
    endtask

    task automatic report_test(input int test, input int errs);
        if (errs == 0) begin
            $display("test %0d (%s): ok", test, test_name[test]);
        end else begin
            $display("test %0d (%s): %0d mismatches", test, test_name[test], errs);
        end
    endtask

    initial begin
        int cur_test;
        int start_errs;
        int runs;
        clk        = 1'b0;
        rst_l      = 1'b0;
        cmd        = CMD_NONE;
        spawn_type = BLANK;
        rd_row     = 5'd0;
        rd_col     = 4'd0;
        errors     = 0;
        runs       = 1;
        build_table();
        repeat (4) @(posedge clk);
        #1;
        rst_l      = 1'b1;
        cur_test   = int'(steps[0].test);
        start_errs = 0;
        foreach (steps[i]) begin
            if (int'(steps[i].test) != cur_test) begin
                report_test(cur_test, errors - start_errs);
                cur_test   = int'(steps[i].test);
                start_errs = errors;
                runs++;
            end
            run_step(steps[i]);
        end
        report_test(cur_test, errors - start_errs);
        $display("test runs: %0d, steps: %0d, errors: %0d", runs, steps.size(), errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tetris_core.f */
verilog/tetris_pkg.sv
verilog/piece_control.sv
verilog/move_checker.sv
verilog/playfield_store.sv
verilog/tspin_detector.sv
verilog/tetris_core.sv
tests/tetris_core_assertions.sv
tests/tetris_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds and runs the tetris_core testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tetris_core.f \
    --top-module tetris_core_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/Vtetris_core_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "NO ERRORS"; then
    exit 0
fi
exit 1
